/* Makefile */
TOP := bn_layer_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f verilog/*.sv verilog/*.svh tests/*.sv
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

# pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* build.f */
+incdir+verilog
verilog/bn_pkg.sv
verilog/sat_alu.sv
verilog/coeff_bank.sv
verilog/bn_ctrl.sv
verilog/bn_datapath.sv
verilog/bn_layer_top.sv
tests/bn_layer_tb.sv

/* tests/bn_layer_tb.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module bn_layer_tb;

  import bn_pkg::*;

  // wait limits in cycles
  localparam int ACK_LIMIT   = 20;
  localparam int STALL_LIMIT = 100;
  localparam int DRAIN_LIMIT = 50;

  logic                            clk_i;
  logic                            reset_i;
  logic                            valid_i;
  logic                            ready_o;
  logic signed [`BN_WORD_SIZE-1:0] data_i;
  logic                            valid_o;
  logic                            ready_i;
  logic signed [`BN_WORD_SIZE-1:0] data_o;
  logic                            wb_cyc_i;
  logic                            wb_stb_i;
  logic                            wb_we_i;
  logic [`BN_WB_ADR_W-1:0]         wb_adr_i;
  logic [`BN_WORD_SIZE-1:0]        wb_dat_i;
  logic [`BN_WORD_SIZE-1:0]        wb_dat_o;
  logic                            wb_ack_o;

  // model of the coefficient rams
  // indexed by table select then channel
  logic signed [`BN_WORD_SIZE-1:0] coef_tab [4][`BN_CHANNELS];

  // accepted words still owed an output
  logic signed [`BN_WORD_SIZE-1:0] word_q [$];
  int chan_q [$];
  int cyc_q [$];

  logic [31:0] lfsr_q;
  bit lat_check;
  int errors;
  int checks;
  int test_base;

  // monitor state owned by the checker process
  int cyc = 0;
  int acc_chan = 0;
  int in_count = 0;
  int out_count = 0;
  int sat_count = 0;
  int mon_errors = 0;
  int mon_checks = 0;
  bit stall_prev = 1'b0;
  logic signed [`BN_WORD_SIZE-1:0] data_prev;

  bn_layer_top UUT (.*);

  always #5 clk_i = ~clk_i;

  // fibonacci lfsr with taps 32 22 2 1
  // one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic int sat16(int v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
  endfunction

  // reference model of (x - mean) * var * scale + offset
  // products drop 14 fraction bits by arithmetic shift
  // every step clamps
  function automatic logic signed [15:0] bn_expected(logic signed [15:0] x, int c);
    int t;
    t = sat16(int'(x) - int'(coef_tab[COEF_MEAN][c]));
    t = sat16((t * int'(coef_tab[COEF_VAR][c])) >>> `BN_N_SIZE);
    t = sat16((t * int'(coef_tab[COEF_SCALE][c])) >>> `BN_N_SIZE);
    t = sat16(t + int'(coef_tab[COEF_OFFSET][c]));
    return t[15:0];
  endfunction

  // table in bits 5:4 and channel in 2:0
  // bit 3 is unused
  function automatic logic [`BN_WB_ADR_W-1:0] coef_addr(int s, int i, logic hole);
    return {2'(s), hole, 3'(i)};
  endfunction

  function automatic logic signed [15:0] pick_word(bit extreme, int k);
    logic signed [15:0] corner [4];
    corner = '{16'sh7fff, 16'sh8000, 16'sh4000, 16'shc000};
    if (extreme) return corner[k % 4];
    return 16'(rand_bits(16));
  endfunction

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      $display("[FAIL] %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("%0d checks, %0d errors", checks + mon_checks, errors + mon_errors + 1);
    $display("Errors found");
    $finish;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors + mon_errors - test_base);
    test_base = errors + mon_errors;
  endtask

  // one classic cycle held until ack
  task automatic bus_cycle(input logic we, input logic [`BN_WB_ADR_W-1:0] adr,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > ACK_LIMIT) begin
        abort_run("wishbone ack never came");
      end
    end while (!wb_ack_o);
    rdat = wb_dat_o;
    // strobe seen one edge after it is driven
    // ack follows one edge later
    expect_true(waited == 2, "wishbone ack not one cycle after the strobe");
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(negedge clk_i);
    expect_true(!wb_ack_o, "wishbone ack longer than one cycle");
  endtask

  task automatic write_coef(input int s, input int i, input logic [15:0] val);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, coef_addr(s, i, 1'b0), val, unused_rd);
    coef_tab[s][i] = val;
  endtask

  task automatic load_random_coefs();
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < `BN_CHANNELS; i++) begin
        write_coef(s, i, 16'(rand_bits(16)));
      end
    end
  endtask

  // offer n words with optionally random valid and ready
  task automatic stream_words(input int n, input bit rnd_hs, input bit extreme);
    int sent;
    int waited;
    bit offer;
    logic signed [`BN_WORD_SIZE-1:0] w;
    sent = 0;
    waited = 0;
    offer = 1'b0;
    w = pick_word(extreme, 0);
    while (sent < n) begin
      @(posedge clk_i);
      // an offered word stays offered until taken
      if (!offer) begin
        offer = !rnd_hs || (rand_bits(1) != 0);
      end
      valid_i <= offer;
      data_i  <= w;
      ready_i <= !rnd_hs || (rand_bits(1) != 0);
      @(negedge clk_i);
      if (valid_i && ready_o) begin
        sent++;
        offer = 1'b0;
        w = pick_word(extreme, sent);
        waited = 0;
      end else begin
        waited++;
        if (waited > STALL_LIMIT) begin
          abort_run("input stream made no progress");
        end
      end
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
    ready_i <= 1'b1;
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (valid_o || word_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        abort_run("outputs did not drain");
      end
      @(negedge clk_i);
    end
  endtask

  // checker sampled mid cycle where everything is settled
  always @(negedge clk_i) begin
    logic signed [`BN_WORD_SIZE-1:0] w;
    logic signed [`BN_WORD_SIZE-1:0] exp;
    int c;
    int c0;
    cyc++;
    if (reset_i) begin
      word_q.delete();
      chan_q.delete();
      cyc_q.delete();
      acc_chan = 0;
      stall_prev = 1'b0;
    end else begin
      mon_checks++;
      assert (ready_o == (!valid_o || ready_i)) else begin
        $display("[FAIL] %0t: ready_o breaks the helpful rule", $time);
        mon_errors++;
      end
      if (stall_prev) begin
        mon_checks++;
        assert (valid_o && data_o == data_prev) else begin
          $display("[FAIL] %0t: output changed while stalled", $time);
          mon_errors++;
        end
      end
      // pop before push
      // the output word is always the older one
      if (valid_o && ready_i) begin
        // every transfer counts, spurious ones too
        out_count++;
        if (word_q.size() == 0) begin
          $display("output transfer at %0t with no accepted word behind it", $time);
          mon_errors++;
        end else begin
          w = word_q.pop_front();
          c = chan_q.pop_front();
          c0 = cyc_q.pop_front();
          exp = bn_expected(w, c);
          mon_checks++;
          assert (data_o == exp) else begin
            $display("[FAIL] %0t: channel %0d expected %0d got %0d", $time, c, exp, data_o);
            mon_errors++;
          end
          if (lat_check) begin
            mon_checks++;
            assert (cyc - c0 == 1) else begin
              $display("[FAIL] %0t: output latency %0d cycles", $time, cyc - c0);
              mon_errors++;
            end
          end
          // words seen on the output rails
          if (data_o == 16'sh7fff || data_o == 16'sh8000) begin
            sat_count++;
          end
        end
      end
      if (valid_i && ready_o) begin
        word_q.push_back(data_i);
        chan_q.push_back(acc_chan);
        cyc_q.push_back(cyc);
        acc_chan = (acc_chan + 1) % `BN_CHANNELS;
        in_count++;
      end
      stall_prev = valid_o && !ready_i;
      data_prev = data_o;
    end
  end

  initial begin
    logic [15:0] rd;
    int sat_base;
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    valid_i  = 1'b0;
    data_i   = '0;
    ready_i  = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    lfsr_q    = 32'h5d1ca738;
    lat_check = 1'b0;
    errors    = 0;
    checks    = 0;
    test_base = 0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    @(negedge clk_i);
    expect_true(!valid_o && ready_o && !wb_ack_o, "idle outputs after reset");
    end_test(1, "reset state");

    // readback sets the unused bit 3 at random
    load_random_coefs();
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < `BN_CHANNELS; i++) begin
        bus_cycle(1'b0, coef_addr(s, i, rand_bits(1) != 0), '0, rd);
        checks++;
        assert (rd == coef_tab[s][i]) else begin
          $display("[FAIL] %0t: table %0d channel %0d wrote %h read %h",
                   $time, s, i, coef_tab[s][i], rd);
          errors++;
        end
      end
    end
    end_test(2, "coefficient write and readback");

    lat_check = 1'b1;
    stream_words(3 * `BN_CHANNELS, 1'b0, 1'b0);
    drain_outputs();
    lat_check = 1'b0;
    expect_true(in_count == out_count, "word count differs at full rate");
    end_test(3, "three frames at full rate");

    stream_words(48, 1'b1, 1'b0);
    drain_outputs();
    expect_true(in_count == out_count, "words lost or duplicated under random handshake");
    end_test(4, "random valid and ready");

    // coefficients near full scale so every stage can clip
    for (int i = 0; i < `BN_CHANNELS; i++) begin
      write_coef(int'(COEF_MEAN), i, (i % 2 == 1) ? 16'h7fff : 16'h8000);
      write_coef(int'(COEF_VAR), i, (i < 4) ? 16'h7fff : 16'h8000);
      write_coef(int'(COEF_SCALE), i, 16'h7fff);
      write_coef(int'(COEF_OFFSET), i, 16'(i * 4096 - 16384));
    end
    sat_base = sat_count;
    stream_words(2 * `BN_CHANNELS, 1'b0, 1'b1);
    drain_outputs();
    expect_true(sat_count > sat_base, "no clamped output in the saturation test");
    end_test(5, "saturation");

    // stop three words into a frame
    // a word is offered during reset
    load_random_coefs();
    stream_words(3, 1'b0, 1'b0);
    @(posedge clk_i);
    reset_i <= 1'b1;
    valid_i <= 1'b1;
    data_i  <= 16'(rand_bits(16));
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    valid_i <= 1'b0;
    @(negedge clk_i);
    expect_true(!valid_o, "stale output after reset");
    stream_words(`BN_CHANNELS, 1'b1, 1'b0);
    drain_outputs();
    end_test(6, "reset mid frame");

    $display("%0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog/bn_ctrl.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module bn_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // upstream handshake
  input  logic                 valid_i,
  output logic                 ready_o,
  // downstream handshake
  output logic                 valid_o,
  input  logic                 ready_i,
  // datapath load strobe
  output logic                 en_o,
  // channel index for the next cycle
  output logic [`BN_IDX_W-1:0] chan_idx_n_o
);

  // output register holds a word
  logic full_r;

  // channel of the word currently offered upstream
  logic [`BN_IDX_W-1:0] count_r;
  logic [`BN_IDX_W-1:0] count_n;

  assign valid_o = full_r;

  // helpful consumer
  // room when empty or when the held word leaves this cycle
  assign ready_o = ~full_r | ready_i;

  // accept on handshake
  assign en_o = valid_i & ready_o;

  // one entry occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (en_o) begin
      full_r <= 1'b1;
    end else if (ready_i) begin
      full_r <= 1'b0;
    end
  end

  // next channel
  // computed ahead so the coefficient ram read lines up with the word
  always_comb begin
    if (reset_i) begin
      count_n = '0;
    end else if (en_o) begin
      if (count_r == `BN_IDX_W'(`BN_CHANNELS - 1)) begin
        count_n = '0;
      end else begin
        count_n = count_r + 1'b1;
      end
    end else begin
      count_n = count_r;
    end
  end

  always_ff @(posedge clk_i) begin
    count_r <= count_n;
  end

  assign chan_idx_n_o = count_n;

  // stalled output stays put and blocks the input
  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |-> (!en_o ##1 valid_o));

  // counter stays inside the frame
  a_count_range: assert property (@(posedge clk_i) disable iff (reset_i)
    int'(count_r) <= `BN_CHANNELS - 1);

endmodule

/* verilog/bn_datapath.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module bn_datapath (
  input  logic                            clk_i,
  input  logic                            en_i,
  // word being offered upstream
  input  logic signed [`BN_WORD_SIZE-1:0] data_i,
  // coefficients of that word's channel
  input  logic signed [`BN_WORD_SIZE-1:0] mean_i,
  input  logic signed [`BN_WORD_SIZE-1:0] var_i,
  input  logic signed [`BN_WORD_SIZE-1:0] scale_i,
  input  logic signed [`BN_WORD_SIZE-1:0] offset_i,
  // registered result
  output logic signed [`BN_WORD_SIZE-1:0] data_o
);

  import bn_pkg::*;

  logic signed [`BN_WORD_SIZE-1:0] centered;
  logic signed [`BN_WORD_SIZE-1:0] normed;
  logic signed [`BN_WORD_SIZE-1:0] scaled;
  logic signed [`BN_WORD_SIZE-1:0] result;

  // x - mean
  sat_alu #(.OP(ALU_SUB)) u_sub (
    .a_i    (data_i),
    .b_i    (mean_i),
    .data_o (centered)
  );

  // times inverse std dev
  sat_alu #(.OP(ALU_MUL)) u_mul_var (
    .a_i    (centered),
    .b_i    (var_i),
    .data_o (normed)
  );

  // times scale
  sat_alu #(.OP(ALU_MUL)) u_mul_scale (
    .a_i    (normed),
    .b_i    (scale_i),
    .data_o (scaled)
  );

  // plus offset
  sat_alu #(.OP(ALU_ADD)) u_add (
    .a_i    (scaled),
    .b_i    (offset_i),
    .data_o (result)
  );

  // output stage
  // holds while the downstream side stalls
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      data_o <= result;
    end
  end

endmodule

/* verilog/bn_defs.svh */
`ifndef BN_DEFS_SVH
`define BN_DEFS_SVH

// data and coefficient word width
`define BN_WORD_SIZE 16

// fraction bits of the Qm.n format
`define BN_N_SIZE 14

// channels per frame
// also the depth of each coefficient table
`define BN_CHANNELS 8

// channel index width
`define BN_IDX_W 3

// wishbone word address
// bits 5:4 pick the table, bits 2:0 pick the channel
`define BN_WB_ADR_W 6

`endif

/* verilog/bn_layer_top.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module bn_layer_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // stream in
  input  logic                            valid_i,
  output logic                            ready_o,
  input  logic signed [`BN_WORD_SIZE-1:0] data_i,
  // stream out
  output logic                            valid_o,
  input  logic                            ready_i,
  output logic signed [`BN_WORD_SIZE-1:0] data_o,
  // coefficient port
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [`BN_WB_ADR_W-1:0]         wb_adr_i,
  input  logic [`BN_WORD_SIZE-1:0]        wb_dat_i,
  output logic [`BN_WORD_SIZE-1:0]        wb_dat_o,
  output logic                            wb_ack_o
);

  logic                            en;
  logic [`BN_IDX_W-1:0]            chan_idx_n;
  logic signed [`BN_WORD_SIZE-1:0] mean;
  logic signed [`BN_WORD_SIZE-1:0] var_c;
  logic signed [`BN_WORD_SIZE-1:0] scale;
  logic signed [`BN_WORD_SIZE-1:0] offset;

  // handshake and channel tracking
  bn_ctrl u_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .en_o         (en),
    .chan_idx_n_o (chan_idx_n)
  );

  // per channel coefficients
  // read one cycle ahead of use
  coeff_bank u_coeff (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .rd_idx_i (chan_idx_n),
    .mean_o   (mean),
    .var_o    (var_c),
    .scale_o  (scale),
    .offset_o (offset),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  // normalize and register
  bn_datapath u_dp (
    .clk_i    (clk_i),
    .en_i     (en),
    .data_i   (data_i),
    .mean_i   (mean),
    .var_i    (var_c),
    .scale_i  (scale),
    .offset_i (offset),
    .data_o   (data_o)
  );

endmodule

/* verilog/bn_pkg.sv */
package bn_pkg;

  // operation of one saturating alu stage
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_MUL
  } alu_op_e;

  // coefficient table select
  // encoding matches the upper wishbone address bits
  typedef enum logic [1:0] {
    // subtracted from the input first
    COEF_MEAN   = 2'd0,
    // inverse standard deviation
    COEF_VAR    = 2'd1,
    // learned gain
    COEF_SCALE  = 2'd2,
    // learned bias
    COEF_OFFSET = 2'd3
  } coef_sel_e;

endpackage

/* verilog/coeff_bank.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module coeff_bank (
  input  logic                            clk_i,
  input  logic                            reset_i,
  // stream read port
  input  logic [`BN_IDX_W-1:0]            rd_idx_i,
  output logic signed [`BN_WORD_SIZE-1:0] mean_o,
  output logic signed [`BN_WORD_SIZE-1:0] var_o,
  output logic signed [`BN_WORD_SIZE-1:0] scale_o,
  output logic signed [`BN_WORD_SIZE-1:0] offset_o,
  // wishbone classic slave
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [`BN_WB_ADR_W-1:0]         wb_adr_i,
  input  logic [`BN_WORD_SIZE-1:0]        wb_dat_i,
  output logic [`BN_WORD_SIZE-1:0]        wb_dat_o,
  output logic                            wb_ack_o
);

  import bn_pkg::*;

  // one small ram per coefficient kind
  logic signed [`BN_WORD_SIZE-1:0] mean_mem   [`BN_CHANNELS];
  logic signed [`BN_WORD_SIZE-1:0] var_mem    [`BN_CHANNELS];
  logic signed [`BN_WORD_SIZE-1:0] scale_mem  [`BN_CHANNELS];
  logic signed [`BN_WORD_SIZE-1:0] offset_mem [`BN_CHANNELS];

  coef_sel_e             wb_sel;
  logic [`BN_IDX_W-1:0]  wb_idx;
  logic                  wb_req;

  // address decode
  // bit 3 is a hole in the map and is not looked at
  assign wb_sel = coef_sel_e'(wb_adr_i[`BN_WB_ADR_W-1 -: 2]);
  assign wb_idx = wb_adr_i[`BN_IDX_W-1:0];

  // new request only while no ack is out
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // stream side
  // address this cycle gives data next cycle
  always_ff @(posedge clk_i) begin
    mean_o   <= mean_mem[rd_idx_i];
    var_o    <= var_mem[rd_idx_i];
    scale_o  <= scale_mem[rd_idx_i];
    offset_o <= offset_mem[rd_idx_i];
  end

  // bus write lands on the ack edge
  always_ff @(posedge clk_i) begin
    if (wb_req && wb_we_i) begin
      case (wb_sel)
        COEF_MEAN:   mean_mem[wb_idx]   <= wb_dat_i;
        COEF_VAR:    var_mem[wb_idx]    <= wb_dat_i;
        COEF_SCALE:  scale_mem[wb_idx]  <= wb_dat_i;
        COEF_OFFSET: offset_mem[wb_idx] <= wb_dat_i;
      endcase
    end
  end

  // bus read data registered alongside the ack
  always_ff @(posedge clk_i) begin
    if (wb_req && !wb_we_i) begin
      case (wb_sel)
        COEF_MEAN:   wb_dat_o <= mean_mem[wb_idx];
        COEF_VAR:    wb_dat_o <= var_mem[wb_idx];
        COEF_SCALE:  wb_dat_o <= scale_mem[wb_idx];
        COEF_OFFSET: wb_dat_o <= offset_mem[wb_idx];
      endcase
    end
  end

  // single cycle ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
    end
  end

  // ack pulses never run into each other
  a_ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

/* verilog/sat_alu.sv */
`timescale 1ns/1ps
`include "bn_defs.svh"

module sat_alu #(
  parameter bn_pkg::alu_op_e OP = bn_pkg::ALU_ADD
) (
  input  logic signed [`BN_WORD_SIZE-1:0] a_i,
  input  logic signed [`BN_WORD_SIZE-1:0] b_i,
  output logic signed [`BN_WORD_SIZE-1:0] data_o
);

  import bn_pkg::*;

  // double width holds any product or sum before the clamp
  localparam int WIDE_W = 2 * `BN_WORD_SIZE;

  // clamp limits of the 16 bit result, sign extended
  localparam logic signed [WIDE_W-1:0] SAT_MAX = WIDE_W'((2 ** (`BN_WORD_SIZE - 1)) - 1);
  localparam logic signed [WIDE_W-1:0] SAT_MIN = -WIDE_W'(2 ** (`BN_WORD_SIZE - 1));

  logic signed [WIDE_W-1:0] a_w;
  logic signed [WIDE_W-1:0] b_w;
  logic signed [WIDE_W-1:0] full;

  // sign extension to the wide format
  assign a_w = a_i;
  assign b_w = b_i;

  // raw result
  // OP is fixed per instance so only one branch is built
  always_comb begin
    case (OP)
      // product carries 2n fraction bits
      // shift back down to n, truncating toward minus infinity
      ALU_MUL: full = (a_w * b_w) >>> `BN_N_SIZE;
      ALU_SUB: full = a_w - b_w;
      default: full = a_w + b_w;
    endcase
  end

  // saturate into the word range
  always_comb begin
    if (full > SAT_MAX) begin
      data_o = SAT_MAX[`BN_WORD_SIZE-1:0];
    end else if (full < SAT_MIN) begin
      data_o = SAT_MIN[`BN_WORD_SIZE-1:0];
    end else begin
      data_o = full[`BN_WORD_SIZE-1:0];
    end
  end

endmodule
